// File: tetris_cases.txt
// Columns: tick gap in idle cycles, expected landing row offset (both hex)
// Last line: FF marker, then the number of pieces that land before game over
01 15   // I on the floor
00 13   // O, back-to-back ticks
02 11   // T
03 0F   // S
00 0D   // Z
01 0B   // J
04 09   // L
00 08   // I again after the wrap
02 06   // O
01 04   // T
00 02   // S
03 00   // Z stuck right at the top
FF 0C

// File: tetris_core.f
tetris_pkg.sv
drop_if.sv
piece_gen.sv
drop_engine.sv
playfield_store.sv
game_ctrl.sv
tetris_core.sv
tb_checker.sv
tb_tetris.sv

// File: Bender.yml
package:
  name: tetris_core

sources:
  - files:
      - tetris_pkg.sv
      - drop_if.sv
      - piece_gen.sv
      - drop_engine.sv
      - playfield_store.sv
      - game_ctrl.sv
      - tetris_core.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_tetris.sv

// File: tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris import tetris_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       tick;
    grid_t      display;
    logic       landed;
    logic       game_over;
    int         pass_cnt;
    int         fail_cnt;
    logic       done;
    logic [7:0] cases_mem [0:63];   // Gap and offset pairs
    integer     seed;               // Jitter source
    int         num_cases;
    bit         aborted;            // Timeout or bad cases file

    tetris_core UUT (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .display   (display),
        .landed    (landed),
        .game_over (game_over)
    );

    tb_checker u_check (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .display   (display),
        .landed    (landed),
        .game_over (game_over),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt),
        .done      (done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;          // 20 ns period

    // Tick every gap+1 cycles until the piece lands; status 0 landed, 1 timeout, 2 over
    task automatic drop_piece(input int gap, input bit jitter, output int status);
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        status = 1;
        while (status == 1 && cycles < 2000) begin
            @(posedge clk);
            if (idle == 0) begin
                tick <= 1'b1;
                idle = gap;
                if (jitter)
                    idle = idle + ($unsigned($random(seed)) % 4);  // 0..3 extra
            end else begin
                tick <= 1'b0;
                idle = idle - 1;
            end
            @(negedge clk);
            if (landed)
                status = 0;
            else if (game_over)
                status = 2;
            cycles++;
        end
    endtask

    // Sparse ticks while waiting for game_over or the checker
    task automatic tick_until(input bit want_done, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < limit) begin
            @(posedge clk);
            tick <= (cycles % 3 == 0);
            @(negedge clk);
            ok = want_done ? done : game_over;
            cycles++;
        end
    endtask

    initial begin
        int n;
        int status;
        bit ok;
        reset   = 1'b1;
        tick    = 1'b0;
        aborted = 1'b0;
        seed    = 32'h6e72_ac74;
        $readmemh("tetris_cases.txt", cases_mem);
        num_cases = 0;
        while (num_cases < 32 && cases_mem[2*num_cases] !== 8'hFF)
            num_cases++;
        if (num_cases == 32) begin
            $display("The cases file has no end marker");
            aborted = 1'b1;
        end
        repeat (3) @(posedge clk);  // Three clocks in reset
        reset <= 1'b0;
        n = 0;
        while (!aborted && n < num_cases) begin
            drop_piece(cases_mem[2*n], (n % 2) == 1, status);
            if (status == 1) begin
                $display("Case %0d: the piece did not land before the timeout", n);
                aborted = 1'b1;
            end else if (status == 2) begin
                $display("Case %0d: game over came before this piece landed", n);
                aborted = 1'b1;
            end
            n++;
        end
        if (!aborted) begin
            tick_until(1'b0, 200, ok);
            if (!ok) begin
                $display("Game over did not come after the last listed piece");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            tick_until(1'b1, 200, ok);  // Checker holds OVER for a while
            if (!ok) begin
                $display("The checker did not close the game-over case in time");
                aborted = 1'b1;
            end
        end
        $display("Cases passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (!aborted && fail_cnt == 0 && pass_cnt == num_cases + 1)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker import tetris_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  tick,
    input  grid_t display,
    input  logic  landed,
    input  logic  game_over,
    output int    pass_cnt,         // Cases without errors
    output int    fail_cnt,
    output logic  done              // Game-over case closed
);

    logic [7:0] cases_mem [0:63];   // Gap and offset pairs
    int         num_cases;          // Landing lines before the marker
    int         exp_landings;       // From the marker line
    grid_t      model;              // Reference stack
    grid_t      want;
    int         model_idx;          // Piece the core should be showing
    int         case_num;
    int         case_err;
    int         landings;
    int         tick_cnt;           // Ticks seen while falling
    int         hold_cnt;
    int         phase;              // 0 reset, 1 spawn, 2 fall, 3 merged, 4 over, 5 idle

    // Mask into an empty field, by flat bit position, row 0 in the top bits
    function automatic grid_t put_shape(input shape_t s, input int off);
        logic [ROWS*COLS-1:0] flat_g;
        logic [15:0]          flat_s;
        int                   bitpos;
        flat_g = '0;
        flat_s = s;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                bitpos = (ROWS - 1 - (off + r)) * COLS + (COLS - 1 - (SPAWN_COL + c));
                if (flat_s[15 - 4*r - c] && (off + r < ROWS))
                    flat_g[bitpos] = 1'b1;
            end
        end
        return flat_g;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR @ %0t ns: case %0d, %s", $time, case_num, msg);
        case_err++;
    endtask

    // One summary line per case
    task automatic close_case(input string what);
        if (case_err == 0) begin
            pass_cnt++;
            $display("Case %0d %s: ok", case_num, what);
        end else begin
            fail_cnt++;
            $display("Case %0d %s: %0d error(s)", case_num, what, case_err);
        end
        case_err = 0;
    endtask

    initial begin
        $readmemh("tetris_cases.txt", cases_mem);
        num_cases = 0;
        while (num_cases < 32 && cases_mem[2*num_cases] !== 8'hFF)
            num_cases++;
        exp_landings = cases_mem[2*num_cases + 1];  // Count after the marker
    end

    // Sample mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            model     = '0;
            model_idx = 0;              // First piece is I
            case_num  = 0;
            case_err  = 0;
            landings  = 0;
            tick_cnt  = 0;
            hold_cnt  = 0;
            phase     = 0;
            pass_cnt  = 0;
            fail_cnt  = 0;
            done      = 1'b0;
        end else begin
            case (phase)
                0: begin                // SPAWN right after reset
                    if (display !== model)
                        report_error("display not clear after reset");
                    if (landed !== 1'b0 || game_over !== 1'b0)
                        report_error("landed or game_over high after reset");
                    phase = 1;
                end
                1: begin                // First FALLING cycle, box at the top
                    want = model | put_shape(SHAPES[model_idx], 0);
                    if (display !== want)
                        report_error($sformatf("piece %0d not shown at offset 0", model_idx));
                    if (landed)
                        report_error("landed during spawn");
                    if (tick)
                        tick_cnt++;
                    phase = 2;
                end
                2: begin
                    if (landed) begin
                        landings++;
                        if (case_num >= num_cases)
                            report_error("landing beyond the listed pieces");
                        phase = 3;
                    end else if (game_over) begin
                        if (case_num < num_cases)
                            report_error("game over before the listed landing");
                        if (landings != exp_landings)
                            report_error($sformatf("%0d landings, expected %0d",
                                                   landings, exp_landings));
                        phase = 4;
                    end else if (tick) begin
                        tick_cnt++;     // Each one moves or lands the piece
                    end
                end
                3: begin                // SPAWN, merged stack now visible
                    if (landed)
                        report_error("landed high for more than one cycle");
                    if (case_num < num_cases) begin
                        want = model | put_shape(SHAPES[model_idx], cases_mem[2*case_num + 1]);
                        if (display !== want)
                            report_error("merged grid differs from the model");
                        if (tick_cnt != cases_mem[2*case_num + 1] + 1)
                            report_error($sformatf("%0d ticks to land, expected %0d",
                                                   tick_cnt, cases_mem[2*case_num + 1] + 1));
                        model = want;
                    end
                    close_case($sformatf("piece %0d offset %0d", model_idx,
                                         cases_mem[2*case_num + 1]));
                    model_idx = (model_idx + 1) % NUM_PIECES;   // I O T S Z J L, wrap
                    case_num++;
                    tick_cnt  = 0;
                    phase     = 1;
                end
                4: begin                // OVER must hold still
                    if (game_over !== 1'b1)
                        report_error("game_over dropped before reset");
                    if (landed)
                        report_error("landed pulse after game over");
                    if (display !== model)
                        report_error("display changed after game over");
                    hold_cnt++;
                    if (hold_cnt == 16) begin
                        close_case("game over");
                        done  = 1'b1;
                        phase = 5;
                    end
                end
                default: ;              // Finished
            endcase
        end
    end

endmodule

// File: tetris_core.sv
`timescale 1ns/1ps

module tetris_core import tetris_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  tick,         // Gravity enable, one clk wide
    output grid_t display,
    output logic  landed,
    output logic  game_over
);

    logic   spawn;
    logic   merge;
    logic   show_piece;
    shape_t shape;
    grid_t  stored_grid;

    drop_if bus ();             // Controller to engine

    game_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .bus        (bus.ctrl),
        .spawn      (spawn),
        .merge      (merge),
        .show_piece (show_piece),
        .landed     (landed),
        .game_over  (game_over)
    );

    piece_gen u_gen (
        .clk   (clk),
        .reset (reset),
        .spawn (spawn),
        .idx   (),              // Shape already carries the piece
        .shape (shape)
    );

    drop_engine u_engine (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus.eng),
        .shape       (shape),
        .stored_grid (stored_grid)
    );

    playfield_store u_store (
        .clk         (clk),
        .reset       (reset),
        .merge       (merge),
        .piece_grid  (bus.piece_grid),
        .stored_grid (stored_grid),
        .display     (display),
        .show_piece  (show_piece)
    );

endmodule

// File: game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl import tetris_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic tick,          // One-cycle gravity pulse
    drop_if.ctrl bus,
    output logic spawn,         // Advance piece_gen
    output logic merge,         // Write piece into the stack
    output logic show_piece,    // Overlay piece on display
    output logic landed,        // One pulse per landing
    output logic game_over
);

    game_state_t state, next_state;

    // State register
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            state <= SPAWN;
        else
            state <= next_state;
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            SPAWN:   next_state = FALLING;
            FALLING: begin
                // Blocked can only rise in the first falling cycle,
                // later moves are all checked by stuck
                if (bus.blocked)
                    next_state = OVER;
                else if (tick && bus.stuck)
                    next_state = LANDED;
            end
            LANDED:  next_state = SPAWN;    // Stack updated on this edge
            OVER:    next_state = OVER;     // Only reset gets out
            default: next_state = SPAWN;
        endcase
    end

    // Decoded controls
    assign bus.load   = (state == SPAWN);
    assign spawn      = (state == SPAWN);
    assign bus.step   = tick && (state == FALLING) && !bus.blocked;  // Other ticks dropped
    assign merge      = (state == LANDED);
    assign landed     = (state == LANDED);
    assign show_piece = (state == FALLING);

    // Sticky flag, high together with OVER
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            game_over <= 1'b0;
        else if (next_state == OVER)
            game_over <= 1'b1;
    end

endmodule

// File: playfield_store.sv
`timescale 1ns/1ps

module playfield_store import tetris_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  merge,        // Landed piece goes into the stack
    input  grid_t piece_grid,   // Active piece from the engine
    output grid_t stored_grid,  // Permanent stack
    output grid_t display,      // What the player sees
    input  logic  show_piece    // High only while falling
);

    // Stack only ever gains cells until reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            stored_grid <= '0;
        else if (merge)
            stored_grid <= stored_grid | piece_grid;
    end

    // Overlay the falling piece
    always_comb begin
        if (show_piece)
            display = stored_grid | piece_grid;
        else
            display = stored_grid;  // SPAWN, LANDED and OVER
    end

endmodule

// File: drop_engine.sv
`timescale 1ns/1ps

module drop_engine import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    drop_if.eng    bus,
    input  shape_t shape,        // From piece_gen
    input  grid_t  stored_grid   // Permanent stack
);

    shape_t     cur_shape;       // Active mask, zero when no piece
    logic       retire;          // Landing step seen, merge is this cycle
    logic [1:0] bot_row;         // Lowest occupied mask row
    row_off_t   bottom_abs;      // Field row of that mask row
    grid_t      below;           // Piece moved down one row

    // Drop the 4x4 mask into the field at SPAWN_COL and the given offset
    function automatic grid_t place_piece(input shape_t s, input row_off_t off);
        grid_t g;
        g = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (int'(off) + r < ROWS)   // Rows past the floor are empty anyway
                    g[int'(off) + r][SPAWN_COL + c] = s[r][c];
            end
        end
        return g;
    endfunction

    assign bus.piece_grid = place_piece(cur_shape, bus.row_off);

    // Lowest row holding a cell
    always_comb begin
        bot_row = 2'd0;
        for (int r = 0; r < 4; r++) begin
            if (|cur_shape[r])
                bot_row = 2'(r);
        end
    end

    assign bottom_abs = bus.row_off + row_off_t'(bot_row);

    // Shifting the packed field right by one row width moves everything down
    assign below = grid_t'(bus.piece_grid >> COLS);

    assign bus.blocked = |(bus.piece_grid & stored_grid);
    assign bus.stuck   = (bottom_abs >= row_off_t'(ROWS - 1))   // On the floor
                       | (|(below & stored_grid));             // On the stack

    // Piece and offset registers
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cur_shape   <= '0;
            bus.row_off <= '0;
            retire      <= 1'b0;
        end else if (bus.load) begin
            cur_shape   <= shape;           // New piece at the top
            bus.row_off <= '0;
            retire      <= 1'b0;
        end else if (retire) begin
            // Store takes the piece on this edge, then it is gone
            cur_shape   <= '0;
            retire      <= 1'b0;
        end else if (bus.step) begin
            if (bus.stuck)
                retire <= 1'b1;             // Controller goes to LANDED
            else
                bus.row_off <= bus.row_off + 5'd1;
        end
    end

endmodule

// File: piece_gen.sv
`timescale 1ns/1ps

module piece_gen import tetris_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       spawn,   // Advance after the current piece is taken
    output piece_idx_t idx,     // Current piece in the cycle
    output shape_t     shape    // Mask for idx
);

    logic last_piece;

    // Wrap point of the fixed sequence
    assign last_piece = (idx == piece_idx_t'(NUM_PIECES - 1));

    // Cycle counter, first piece after reset is I
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            idx <= '0;
        end else if (spawn) begin
            // Engine grabs shape on this same edge, so step past it
            if (last_piece)
                idx <= '0;
            else
                idx <= idx + 3'd1;
        end
    end

    // Table lookup, purely combinational
    always_comb begin
        if (idx < piece_idx_t'(NUM_PIECES))
            shape = SHAPES[idx];
        else
            shape = '0;         // Index 7 never reached
    end

endmodule

// File: drop_if.sv
`timescale 1ns/1ps

interface drop_if import tetris_pkg::*; ();

    // Controller side
    logic     load;         // Capture new piece at offset 0
    logic     step;         // Tick seen while falling

    // Engine side
    logic     blocked;      // Current position overlaps the stack
    logic     stuck;        // One row lower is not possible
    grid_t    piece_grid;   // Active piece on an empty field
    row_off_t row_off;      // Current box offset

    modport ctrl (
        output load,
        output step,
        input  blocked,
        input  stuck
    );

    modport eng (
        input  load,
        input  step,
        output blocked,
        output stuck,
        output piece_grid,
        output row_off
    );

endinterface

// File: tetris_pkg.sv
package tetris_pkg;

    // Playfield geometry
    localparam int ROWS       = 22;     // Row 0 is the top
    localparam int COLS       = 10;
    localparam int SPAWN_COL  = 3;      // Left edge of the 4x4 piece box
    localparam int NUM_PIECES = 7;

    // Whole playfield, row major, row 0 in the top bits
    typedef logic [0:ROWS-1][0:COLS-1] grid_t;

    typedef logic [2:0] piece_idx_t;    // 0..6
    typedef logic [4:0] row_off_t;      // Box offset 0..21

    // 4x4 occupancy, s[0] is the top row, s[r][0] the left column
    typedef logic [0:3][0:3] shape_t;

    // Controller states
    typedef enum logic [1:0] {
        SPAWN   = 2'd0,                 // Load next piece
        FALLING = 2'd1,                 // Piece moves on ticks
        LANDED  = 2'd2,                 // Merge into the stack
        OVER    = 2'd3                  // Spawn blocked, sticky until reset
    } game_state_t;

    // Tetromino masks, top row always occupied
    // Order I, O, T, S, Z, J, L
    localparam shape_t [0:NUM_PIECES-1] SHAPES = {
        16'b1111_0000_0000_0000,        // I
        16'b1100_1100_0000_0000,        // O
        16'b1110_0100_0000_0000,        // T
        16'b0110_1100_0000_0000,        // S
        16'b1100_0110_0000_0000,        // Z
        16'b1000_1110_0000_0000,        // J
        16'b0010_1110_0000_0000         // L
    };

endpackage
